//--- common/ls_pkg.sv
package ls_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths

    localparam int ID_W = 6;

    typedef logic [31:0] word_t;

    // Low operation code, same encoding as the RISC-V funct3 field
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_width_t;

    ////////////////////////////////////////////////////////////////////////////
    // Shared records

    // Request from the issue stage
    typedef struct packed {
        ls_width_t         width;
        logic              store;
        word_t             base;
        logic signed [11:0] offset;
        word_t             data;
        logic [ID_W-1:0]   id;
    } ls_issue_t;

    // One request queue entry, store data already lane aligned
    typedef struct packed {
        word_t           addr;
        ls_width_t       width;
        logic            store;
        logic [3:0]      byte_en;
        word_t           data;
        logic [ID_W-1:0] id;
    } ls_entry_t;

    // Load writeback
    typedef struct packed {
        logic [ID_W-1:0] id;
        word_t           result;
    } ls_wb_t;

    // Misalignment fault
    typedef struct packed {
        logic [ID_W-1:0] id;
        word_t           addr;
    } ls_fault_t;

endpackage

//--- design/ls_address_gen.sv
`timescale 1ns/1ps

module ls_address_gen (
    input  logic              clk,
    input  logic              rst,

    input  logic              issue_valid,
    input  ls_pkg::ls_issue_t issue,
    input  logic              full,

    output logic              push,
    output ls_pkg::ls_entry_t entry,

    output logic              fault_valid,
    output ls_pkg::ls_fault_t fault
);

    import ls_pkg::*;

    logic       accept;
    word_t      addr;
    logic       misaligned;
    logic [3:0] byte_en;
    word_t      lane_data;

    assign accept = issue_valid & ~full;

    // Base plus sign-extended 12-bit offset
    assign addr = issue.base + {{20{issue.offset[11]}}, issue.offset};

    ////////////////////////////////////////////////////////////////////////////
    // Alignment and byte lanes

    always_comb begin
        case (issue.width)
            LS_H, LS_HU: misaligned = addr[0];
            LS_W:        misaligned = |addr[1:0];
            default:     misaligned = 1'b0;
        endcase
    end

    always_comb begin
        case (issue.width)
            LS_B, LS_BU: begin
                byte_en   = 4'b0001 << addr[1:0];
                lane_data = {4{issue.data[7:0]}};
            end
            LS_H, LS_HU: begin
                byte_en   = addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{issue.data[15:0]}};
            end
            default: begin
                byte_en   = 4'b1111;
                lane_data = issue.data;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register

    always_ff @(posedge clk) begin
        if (rst) begin
            push        <= 1'b0;
            fault_valid <= 1'b0;
        end else begin
            push        <= accept & ~misaligned;
            fault_valid <= accept & misaligned;
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (accept) begin
            entry.addr    <= addr;
            entry.width   <= issue.width;
            entry.store   <= issue.store;
            entry.byte_en <= byte_en;
            entry.data    <= lane_data;
            entry.id      <= issue.id;
            fault.id      <= issue.id;
            fault.addr    <= addr;
        end
    end

    // A request refused while full stays on the bus until the queue has room
    hold_while_full: assert property (@(posedge clk) disable iff (rst)
        issue_valid && full |=> issue_valid && $stable(issue))
        else $error("request withdrawn while the queue was full");

endmodule

//--- design/ls_request_queue.sv
`timescale 1ns/1ps

module ls_request_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              push,
    input  ls_pkg::ls_entry_t entry_in,
    input  logic              pop,

    output ls_pkg::ls_entry_t head,
    output logic              not_empty,
    output logic              full
);

    import ls_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    ls_entry_t        mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // First word falls through
    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

    // Lookahead full so the request registered in the producer still fits
    assign full = ((CNT_W+1)'(count) + (CNT_W+1)'(push)) >= (CNT_W+1)'(QUEUE_DEPTH);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= entry_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> (count < CNT_W'(QUEUE_DEPTH)))
        else $error("request queue overflow");

    no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> (count != '0))
        else $error("request queue underflow");

endmodule

//--- data_port/ls_local_mem.sv
`timescale 1ns/1ps

module ls_local_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic [$clog2(MEM_WORDS)-1:0] word_index,
    input  logic [3:0]                   byte_en,
    input  logic                         write,
    input  ls_pkg::word_t                write_data,
    output ls_pkg::word_t                read_data
);

    import ls_pkg::*;

    word_t mem [MEM_WORDS];

    // Byte-lane writes
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (write && byte_en[i]) begin
                mem[word_index][i*8 +: 8] <= write_data[i*8 +: 8];
            end
        end
    end

    // Registered read, old data on a write to the same word
    always_ff @(posedge clk) begin
        read_data <= mem[word_index];
    end

endmodule

//--- data_port/ls_load_align.sv
`timescale 1ns/1ps

module ls_load_align (
    input  ls_pkg::word_t     word,
    input  ls_pkg::ls_width_t width,
    input  logic [1:0]        byte_offset,
    output ls_pkg::word_t     result
);

    import ls_pkg::*;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // Accesses are aligned, so a halfword sits in one half of the word
    assign byte_lane = word[byte_offset*8 +: 8];
    assign half_lane = byte_offset[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (width)
            LS_B:    result = {{24{byte_lane[7]}}, byte_lane};
            LS_BU:   result = {24'b0, byte_lane};
            LS_H:    result = {{16{half_lane[15]}}, half_lane};
            LS_HU:   result = {16'b0, half_lane};
            default: result = word;
        endcase
    end

endmodule

//--- data_port/ls_data_port.sv
`timescale 1ns/1ps

module ls_data_port #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst,

    input  ls_pkg::ls_entry_t head,
    input  logic              not_empty,
    output logic              pop,

    output logic              wb_done,
    output ls_pkg::ls_wb_t    wb
);

    import ls_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic             write;
    logic             load_pop;
    logic [IDX_W-1:0] word_index;
    word_t            read_data;
    word_t            result;

    // Attributes of the load in its RAM read
    logic             load_valid;
    logic [ID_W-1:0]  ld_id;
    ls_width_t        ld_width;
    logic [1:0]       ld_offset;

    // RAM serves one access per cycle, so drain every cycle
    assign pop      = not_empty;
    assign write    = pop & head.store;
    assign load_pop = pop & ~head.store;

    assign word_index = IDX_W'(head.addr[31:2] % MEM_WORDS);

    ls_local_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) ls_local_mem_i (
        .clk        (clk),
        .word_index (word_index),
        .byte_en    (head.byte_en),
        .write      (write),
        .write_data (head.data),
        .read_data  (read_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Load writeback

    always_ff @(posedge clk) begin
        if (rst) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= load_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (load_pop) begin
            ld_id     <= head.id;
            ld_width  <= head.width;
            ld_offset <= head.addr[1:0];
        end
    end

    ls_load_align ls_load_align_i (
        .word        (read_data),
        .width       (ld_width),
        .byte_offset (ld_offset),
        .result      (result)
    );

    assign wb_done   = load_valid;
    assign wb.id     = ld_id;
    assign wb.result = result;

    // Lane select in the aligner needs an aligned entry
    pop_aligned: assert property (@(posedge clk) disable iff (rst)
        pop |-> !((head.width inside {LS_H, LS_HU}) && head.addr[0])
             && !((head.width == LS_W) && (head.addr[1:0] != 2'b00)))
        else $error("misaligned entry popped from the queue");

endmodule

//--- design/ls_unit.sv
`timescale 1ns/1ps

module ls_unit #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MEM_WORDS   = 256
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              issue_valid,
    input  ls_pkg::ls_issue_t issue,
    output logic              issue_ready,

    output logic              wb_done,
    output ls_pkg::ls_wb_t    wb,

    output logic              fault_valid,
    output ls_pkg::ls_fault_t fault
);

    import ls_pkg::*;

    // Producer to queue
    logic      push;
    ls_entry_t entry;
    logic      full;

    // Queue to consumer
    ls_entry_t head;
    logic      not_empty;
    logic      pop;

    ////////////////////////////////////////////////////////////////////////////
    // Issue side

    // Queue full already counts the entry in flight from the producer
    assign issue_ready = ~full;

    ls_address_gen ls_address_gen_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .full        (full),
        .push        (push),
        .entry       (entry),
        .fault_valid (fault_valid),
        .fault       (fault)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Request buffer

    ls_request_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) ls_request_queue_i (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .entry_in  (entry),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .full      (full)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory side

    ls_data_port #(
        .MEM_WORDS (MEM_WORDS)
    ) ls_data_port_i (
        .clk       (clk),
        .rst       (rst),
        .head      (head),
        .not_empty (not_empty),
        .pop       (pop),
        .wb_done   (wb_done),
        .wb        (wb)
    );

endmodule

//--- test/ls_tb_tasks.svh
`ifndef LS_TB_TASKS_SVH
`define LS_TB_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Model address rules

// Base plus sign-extended offset
function automatic word_t effective_addr(ls_issue_t req);
    return req.base + word_t'(int'(req.offset));
endfunction

// Byte slot in the model RAM, word index wraps at MEM_WORDS
function automatic int byte_slot(word_t addr);
    return int'((addr >> 2) % word_t'(MEM_WORDS)) * 4 + int'(addr[1:0]);
endfunction

function automatic bit is_misaligned(ls_issue_t req);
    word_t a;
    a = effective_addr(req);
    if (req.width == LS_W) begin
        return a[1:0] != 2'b00;
    end
    return (req.width inside {LS_H, LS_HU}) && a[0];
endfunction

// Little-endian byte writes, only the addressed bytes
function automatic void apply_store(ls_issue_t req);
    int s;
    int n;
    s = byte_slot(effective_addr(req));
    n = (req.width == LS_W) ? 4 : ((req.width == LS_H) ? 2 : 1);
    for (int i = 0; i < n; i++) begin
        model_mem[s + i] = req.data[i*8 +: 8];
    end
endfunction

function automatic word_t expected_load(ls_issue_t req);
    int          s;
    logic [15:0] h;
    s = byte_slot(effective_addr(req));
    case (req.width)
        LS_B:    return {{24{model_mem[s][7]}}, model_mem[s]};
        LS_BU:   return {24'b0, model_mem[s]};
        LS_W:    return {model_mem[s+3], model_mem[s+2], model_mem[s+1], model_mem[s]};
        default: begin
            h = {model_mem[s+1], model_mem[s]};
            return (req.width == LS_H) ? {{16{h[15]}}, h} : {16'b0, h};
        end
    endcase
endfunction

////////////////////////////////////////////////////////////////////////////
// Compare tasks

task automatic compare_wb(ls_wb_t expected, ls_wb_t actual);
    if (actual !== expected) begin
        $display("MISMATCH %s wb expected id %0d data %08h actual id %0d data %08h",
                 cur_test, expected.id, expected.result, actual.id, actual.result);
        errors++;
    end
endtask

task automatic compare_fault(ls_fault_t expected, ls_fault_t actual);
    if (actual !== expected) begin
        $display("MISMATCH %s fault expected id %0d addr %08h actual id %0d addr %08h",
                 cur_test, expected.id, expected.addr, actual.id, actual.addr);
        errors++;
    end
endtask

`endif

//--- test/ls_unit_tb.sv
`timescale 1ns/1ps

module ls_unit_tb;

    import ls_pkg::*;

    // Depth 2 lets back-to-back issue fill the queue
    localparam int QUEUE_DEPTH = 2;
    localparam int MEM_WORDS   = 64;
    localparam int WAIT_LIMIT  = 200;

    logic      clk;
    logic      rst;
    logic      issue_valid;
    ls_issue_t issue;
    logic      issue_ready;
    logic      wb_done;
    ls_wb_t    wb;
    logic      fault_valid;
    ls_fault_t fault;

    // Reference model
    logic [7:0]      model_mem [MEM_WORDS*4];
    ls_wb_t          wb_expect [$];
    ls_fault_t       fault_expect [$];
    word_t           addr_list [$];
    word_t           rng_state;
    logic [ID_W-1:0] next_id;

    string cur_test;
    int    errors;
    int    test_start_errors;
    int    tests_run;
    int    tests_failed;
    logic  saw_stall;
    string abort_reason;
    event  abort_ev;

    `include "ls_tb_tasks.svh"

    ls_unit #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .MEM_WORDS   (MEM_WORDS)
    ) ls_unit_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .wb_done     (wb_done),
        .wb          (wb),
        .fault_valid (fault_valid),
        .fault       (fault)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    function automatic word_t next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic word_t random_addr(ls_width_t width);
        word_t a;
        a = next_random();
        if (width == LS_W) begin
            a[1:0] = 2'b00;
        end else if (width inside {LS_H, LS_HU}) begin
            a[0] = 1'b0;
        end
        return a;
    endfunction

    // Random offset, base picked so the sum lands on addr
    function automatic ls_issue_t make_req(ls_width_t width, logic store, word_t addr);
        ls_issue_t req;
        word_t     r;
        r          = next_random();
        req.width  = width;
        req.store  = store;
        req.offset = r[11:0];
        req.base   = addr - word_t'(int'(req.offset));
        req.data   = next_random();
        req.id     = next_id;
        next_id    = next_id + 1'b1;
        return req;
    endfunction

    task automatic record_accept(ls_issue_t req);
        ls_wb_t    exp_wb;
        ls_fault_t exp_fault;
        if (is_misaligned(req)) begin
            exp_fault.id   = req.id;
            exp_fault.addr = effective_addr(req);
            fault_expect.push_back(exp_fault);
        end else if (req.store) begin
            apply_store(req);
        end else begin
            exp_wb.id     = req.id;
            exp_wb.result = expected_load(req);
            wb_expect.push_back(exp_wb);
        end
    endtask

    // Starts on a rising edge, returns on the edge that takes the request
    task automatic send(ls_issue_t req);
        int   waited;
        logic ready;
        waited = 0;
        ready  = 1'b0;
        issue_valid <= 1'b1;
        issue       <= req;
        while (!ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            ready = (issue_ready === 1'b1);
            if (!ready) begin
                saw_stall = 1'b1;
            end
            @(posedge clk);
            waited++;
        end
        if (ready) begin
            record_accept(req);
        end else begin
            abort_reason = $sformatf("timeout in %s: issue_ready stayed low", cur_test);
            -> abort_ev;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((wb_expect.size() != 0 || fault_expect.size() != 0) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (wb_expect.size() != 0 || fault_expect.size() != 0) begin
            abort_reason = $sformatf("timeout in %s: %0d writebacks and %0d faults missing",
                                     cur_test, wb_expect.size(), fault_expect.size());
            -> abort_ev;
        end
        // Quiet window to catch stray pulses
        repeat (4) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic start_test(string name);
        cur_test          = name;
        test_start_errors = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == test_start_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAILED, %0d errors", cur_test, errors - test_start_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor, sampled mid-cycle

    always @(negedge clk) begin
        if (rst === 1'b0 && wb_done === 1'b1) begin
            if (wb_expect.size() == 0) begin
                $display("%s: writeback with id %0d that no load asked for", cur_test, wb.id);
                errors++;
            end else begin
                compare_wb(wb_expect.pop_front(), wb);
            end
        end
        if (rst === 1'b0 && fault_valid === 1'b1) begin
            if (fault_expect.size() == 0) begin
                $display("%s: fault with id %0d for an aligned request", cur_test, fault.id);
                errors++;
            end else begin
                compare_fault(fault_expect.pop_front(), fault);
            end
        end
    end

    initial begin
        @(abort_ev);
        $display("%s", abort_reason);
        $display("sim failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        ls_width_t w;
        word_t     r;
        word_t     a;
        issue_valid = 1'b0;
        issue       = '0;
        rst         = 1'b1;
        rng_state   = 32'd90755;
        next_id     = '0;
        errors      = 0;
        tests_run   = 0;
        tests_failed = 0;
        saw_stall   = 1'b0;
        cur_test    = "reset";
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        start_test("reset_idle");
        repeat (10) begin
            @(negedge clk);
            if (issue_ready !== 1'b1 || wb_done !== 1'b0 || fault_valid !== 1'b0) begin
                $display("%s: DUT not idle, ready %b wb_done %b fault_valid %b",
                         cur_test, issue_ready, wb_done, fault_valid);
                errors++;
            end
        end
        @(posedge clk);
        finish_test();

        // Every RAM word written once before any load
        cur_test = "fill";
        for (int i = 0; i < MEM_WORDS; i++) begin
            send(make_req(LS_W, 1'b1, word_t'(i * 4)));
        end
        issue_valid <= 1'b0;
        wait_drain();

        start_test("word_store_load");
        addr_list.delete();
        repeat (12) begin
            addr_list.push_back(random_addr(LS_W));
            send(make_req(LS_W, 1'b1, addr_list[$]));
        end
        foreach (addr_list[i]) begin
            send(make_req(LS_W, 1'b0, addr_list[i]));
        end
        issue_valid <= 1'b0;
        wait_drain();
        finish_test();

        start_test("narrow_loads");
        repeat (40) begin
            r = next_random();
            w = r[1] ? (r[0] ? LS_HU : LS_BU) : (r[0] ? LS_H : LS_B);
            send(make_req(w, 1'b0, random_addr(w)));
        end
        issue_valid <= 1'b0;
        wait_drain();
        finish_test();

        start_test("narrow_stores");
        addr_list.delete();
        repeat (20) begin
            r = next_random();
            w = r[0] ? LS_H : LS_B;
            addr_list.push_back(random_addr(w));
            send(make_req(w, 1'b1, addr_list[$]));
        end
        foreach (addr_list[i]) begin
            send(make_req(LS_W, 1'b0, addr_list[i] & ~32'h3));
        end
        issue_valid <= 1'b0;
        wait_drain();
        finish_test();

        start_test("misaligned");
        addr_list.delete();
        repeat (12) begin
            r = next_random();
            w = r[0] ? LS_W : ((r[1] && !r[2]) ? LS_HU : LS_H);
            a = next_random();
            if (w == LS_W && r[3]) begin
                a[1:0] = 2'b10;
            end else begin
                a[0] = 1'b1;
            end
            addr_list.push_back(a);
            send(make_req(w, r[2], a));
        end
        // Words around each refused access must be unchanged
        foreach (addr_list[i]) begin
            send(make_req(LS_W, 1'b0, addr_list[i] & ~32'h3));
            send(make_req(LS_W, 1'b0, (addr_list[i] & ~32'h3) + 32'd4));
        end
        issue_valid <= 1'b0;
        wait_drain();
        finish_test();

        start_test("burst_backpressure");
        saw_stall = 1'b0;
        repeat (4 * QUEUE_DEPTH + 8) begin
            r = next_random();
            w = r[2] ? LS_W : (r[3] ? LS_H : LS_B);
            send(make_req(w, r[1], random_addr(w)));
        end
        issue_valid <= 1'b0;
        wait_drain();
        if (!saw_stall) begin
            $display("%s: issue_ready never dropped during the burst", cur_test);
            errors++;
        end
        finish_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+test
common/ls_pkg.sv
design/ls_address_gen.sv
design/ls_request_queue.sv
data_port/ls_local_mem.sv
data_port/ls_load_align.sv
data_port/ls_data_port.sv
design/ls_unit.sv
test/ls_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ls_unit_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard test/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)
